// ==== Makefile ====
SIM   = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_icache
FLIST = flist.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// ==== flist.f ====
source/icache_pkg.sv
source/icache_way_ram.sv
source/icache_lookup.sv
source/icache_refill_buffer.sv
source/icache_miss_ctrl.sv
source/icache_top.sv
test/axi_mem_model.sv
test/tb_icache.sv

// ==== source/icache_lookup.sv ====
module icache_lookup (
    input  logic                                                      clk,
    input  logic                                                      rst,
    input  logic                                                      req,
    input  logic [icache_pkg::index_width:0]                          index,
    input  logic [icache_pkg::tag_width-1:0]                          tag,
    output logic                                                      index_ok,
    output logic                                                      data_ok,
    output logic [icache_pkg::fetch_width-1:0]                        rdata,
    input  logic                                                      sweeping,
    input  logic                                                      fill_done,
    input  logic [icache_pkg::line_width-1:0]                         fill_line,
    output logic [icache_pkg::index_width-1:0]                        rd_index,
    input  logic [icache_pkg::num_ways-1:0][icache_pkg::tag_width-1:0]  rd_tag,
    input  logic [icache_pkg::num_ways-1:0]                           rd_valid,
    input  logic [icache_pkg::num_ways-1:0][icache_pkg::line_width-1:0] rd_line,
    output logic                                                      miss_valid,
    output logic [icache_pkg::tag_width-1:0]                          miss_tag,
    output logic [icache_pkg::index_width-1:0]                        miss_index,
    output logic                                                      miss_half
);
    import icache_pkg::*;

    // response stage control
    logic resp_valid;
    logic resp_new;
    logic resp_miss;
    logic fill_ok;

    // response stage payload
    logic [tag_width-1:0]   resp_tag;
    logic [index_width-1:0] resp_index;
    logic                   resp_half;
    logic [fetch_width-1:0] fill_rdata;

    logic                   accept;
    logic [num_ways-1:0]    hit_way;
    logic                   any_hit;
    logic                   hit;
    logic [line_width-1:0]  hit_line;
    logic [fetch_width-1:0] hit_rdata;

    //////////////////////////////////////////////////
    // request stage

    // ways are read with the incoming set, result lands with the stage
    assign rd_index = index[index_width:1];

    assign index_ok = req & ~sweeping & (~resp_valid | data_ok);
    assign accept   = req & index_ok;

    //////////////////////////////////////////////////
    // tag compare

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_way[w] = rd_valid[w] && (rd_tag[w] == resp_tag);
            if (hit_way[w]) begin
                hit_line = hit_line | rd_line[w];
            end
        end
    end

    assign any_hit   = |hit_way;
    // way outputs only belong to this request in its first cycle
    assign hit       = resp_new & any_hit;
    assign hit_rdata = hit_line[resp_half*fetch_width +: fetch_width];

    assign miss_valid = (resp_new & ~any_hit) | resp_miss;
    assign miss_tag   = resp_tag;
    assign miss_index = resp_index;
    assign miss_half  = resp_half;

    // fill response goes out the cycle after the array write
    assign data_ok = hit | fill_ok;
    assign rdata   = fill_ok ? fill_rdata : hit_rdata;

    //////////////////////////////////////////////////
    // response stage

    always_ff @(posedge clk) begin
        if (!rst) begin
            resp_valid <= 1'b0;
            resp_new   <= 1'b0;
            resp_miss  <= 1'b0;
            fill_ok    <= 1'b0;
        end else begin
            fill_ok <= fill_done;
            if (accept) begin
                resp_valid <= 1'b1;
                resp_new   <= 1'b1;
                resp_miss  <= 1'b0;
            end else if (hit || fill_done) begin
                resp_valid <= 1'b0;
                resp_new   <= 1'b0;
                resp_miss  <= 1'b0;
            end else if (resp_new) begin
                // no hit, hold until the refill
                resp_new  <= 1'b0;
                resp_miss <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_tag   <= tag;
            resp_index <= index[index_width:1];
            resp_half  <= index[0];
        end
        if (fill_done) begin
            fill_rdata <= fill_line[resp_half*fetch_width +: fetch_width];
        end
    end

endmodule

// ==== source/icache_miss_ctrl.sv ====
module icache_miss_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    output logic                               sweeping,
    input  logic                               miss_valid,
    input  logic [icache_pkg::tag_width-1:0]   miss_tag,
    input  logic [icache_pkg::index_width-1:0] miss_index,
    input  logic                               miss_half,
    output logic [icache_pkg::addr_width-1:0]  araddr,
    output logic                               arvalid,
    input  logic                               arready,
    output logic                               start,
    output logic                               start_half,
    input  logic                               burst_done,
    output logic                               fill_done,
    output logic [icache_pkg::num_ways-1:0]    way_we,
    output logic [icache_pkg::index_width-1:0] wr_index,
    output logic [icache_pkg::tag_width-1:0]   wr_tag,
    output logic                               wr_valid
);
    import icache_pkg::*;

    cache_state_t              state;
    cache_state_t              state_next;
    logic [index_width-1:0]    sweep_cnt;
    logic                      sweep_last;
    plru_t                     plru_mem [num_sets];
    plru_t                     plru_cur;
    plru_t                     plru_next;
    logic [way_sel_width-1:0]  victim_pick;
    logic [way_sel_width-1:0]  victim_way;

    //////////////////////////////////////////////////
    // state machine

    assign sweep_last = (sweep_cnt == index_width'(num_sets - 1));

    always_comb begin
        state_next = state;
        case (state)
            st_sweep: if (sweep_last) state_next = st_run;
            st_run:   if (miss_valid) state_next = st_addr;
            st_addr:  if (arready) state_next = st_fill;
            st_fill:  if (burst_done) state_next = st_write;
            st_write: state_next = st_run;
            default:  state_next = st_sweep;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= st_sweep;
            sweep_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == st_sweep) begin
                sweep_cnt <= sweep_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // pseudo-LRU

    assign plru_cur    = plru_mem[miss_index];
    assign victim_pick = plru_cur[0] ? {1'b1, plru_cur[2]} : {1'b0, plru_cur[1]};

    // point away from the victim at both levels
    always_comb begin
        plru_next    = plru_cur;
        plru_next[0] = ~victim_way[1];
        if (victim_way[1]) begin
            plru_next[2] = ~victim_way[0];
        end else begin
            plru_next[1] = ~victim_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_sweep) begin
            plru_mem[sweep_cnt] <= '0;
        end else if (start) begin
            plru_mem[miss_index] <= plru_next;
        end
        if (state == st_run && miss_valid) begin
            victim_way <= victim_pick;
        end
    end

    //////////////////////////////////////////////////
    // memory and array control

    assign sweeping   = (state == st_sweep);
    assign arvalid    = (state == st_addr);
    assign araddr     = {miss_tag, miss_index, miss_half, {half_byte_width{1'b0}}};
    assign start      = arvalid & arready;
    assign start_half = miss_half;
    assign fill_done  = (state == st_write);

    assign wr_index = sweeping ? sweep_cnt : miss_index;
    assign wr_tag   = miss_tag;
    assign wr_valid = fill_done;

    always_comb begin
        way_we = '0;
        if (sweeping) begin
            way_we = '1;
        end else if (fill_done) begin
            way_we[victim_way] = 1'b1;
        end
    end

endmodule

// ==== source/icache_pkg.sv ====
package icache_pkg;

    //////////////////////////////////////////////////
    // geometry

    localparam int num_ways        = 4;
    localparam int num_sets        = 128;
    localparam int words_per_line  = 8;
    localparam int word_width      = 32;
    localparam int line_width      = words_per_line * word_width;
    localparam int fetch_width     = line_width / 2;

    //////////////////////////////////////////////////
    // address fields

    // tag[31:12] index[11:5] half[4] byte[3:0]
    localparam int addr_width      = 32;
    localparam int tag_width       = 20;
    localparam int index_width     = 7;
    localparam int half_byte_width = 4;

    // word slot inside a line
    localparam int word_sel_width  = 3;
    // way number
    localparam int way_sel_width   = 2;

    //////////////////////////////////////////////////
    // controller

    typedef enum logic [2:0] {
        st_sweep,
        st_run,
        st_addr,
        st_fill,
        st_write
    } cache_state_t;

    // tree pseudo-LRU, one per set
    // bit 0 picks the pair (0 -> ways 0/1, 1 -> ways 2/3)
    // bit 1 picks within the low pair, bit 2 within the high pair
    typedef logic [2:0] plru_t;

endpackage

// ==== source/icache_refill_buffer.sv ====
module icache_refill_buffer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start,
    input  logic                              start_half,
    input  logic                              rvalid,
    input  logic                              rlast,
    input  logic [icache_pkg::word_width-1:0] rdata_mem,
    output logic                              rready,
    output logic [icache_pkg::line_width-1:0] line_data,
    output logic                              burst_done
);
    import icache_pkg::*;

    logic                                       burst_open;
    logic [word_sel_width-1:0]                  beat_idx;
    logic                                       beat;
    logic [words_per_line-1:0][word_width-1:0]  line_q;

    //////////////////////////////////////////////////
    // beat handshake

    assign rready     = burst_open;
    assign beat       = rvalid & rready;
    assign burst_done = beat & rlast;

    // word 0 at the bottom of the line
    assign line_data = line_q;

    //////////////////////////////////////////////////
    // burst tracking

    // wrap burst starts on the requested half
    always_ff @(posedge clk) begin
        if (!rst) begin
            burst_open <= 1'b0;
            beat_idx   <= '0;
        end else if (start) begin
            burst_open <= 1'b1;
            beat_idx   <= {start_half, {(word_sel_width-1){1'b0}}};
        end else if (beat) begin
            // counter rolls over modulo 8
            beat_idx <= beat_idx + 1'b1;
            if (rlast) begin
                burst_open <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // line storage

    always_ff @(posedge clk) begin
        if (beat) begin
            line_q[beat_idx] <= rdata_mem;
        end
    end

endmodule

// ==== source/icache_top.sv ====
module icache_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               req,
    input  logic [icache_pkg::index_width:0]   index,
    input  logic [icache_pkg::tag_width-1:0]   tag,
    output logic                               index_ok,
    output logic                               data_ok,
    output logic [icache_pkg::fetch_width-1:0] rdata,
    output logic [icache_pkg::addr_width-1:0]  araddr,
    output logic                               arvalid,
    input  logic                               arready,
    input  logic [icache_pkg::word_width-1:0]  rdata_mem,
    input  logic                               rlast,
    input  logic                               rvalid,
    output logic                               rready
);
    import icache_pkg::*;

    // way read side
    logic [index_width-1:0]                rd_index;
    logic [num_ways-1:0][tag_width-1:0]    rd_tag;
    logic [num_ways-1:0]                   rd_valid;
    logic [num_ways-1:0][line_width-1:0]   rd_line;

    // way write side
    logic [num_ways-1:0]    way_we;
    logic [index_width-1:0] wr_index;
    logic [tag_width-1:0]   wr_tag;
    logic                   wr_valid;
    logic [line_width-1:0]  line_data;

    // lookup and controller
    logic                   sweeping;
    logic                   fill_done;
    logic                   miss_valid;
    logic [tag_width-1:0]   miss_tag;
    logic [index_width-1:0] miss_index;
    logic                   miss_half;
    logic                   start;
    logic                   start_half;
    logic                   burst_done;

    //////////////////////////////////////////////////
    // ways

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        icache_way_ram u_way (
            .clk      (clk),
            .we       (way_we[w]),
            .wr_index (wr_index),
            .wr_tag   (wr_tag),
            .wr_valid (wr_valid),
            .wr_line  (line_data),
            .rd_index (rd_index),
            .rd_tag   (rd_tag[w]),
            .rd_valid (rd_valid[w]),
            .rd_line  (rd_line[w])
        );
    end

    //////////////////////////////////////////////////
    // control

    icache_lookup u_lookup (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .index      (index),
        .tag        (tag),
        .index_ok   (index_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .sweeping   (sweeping),
        .fill_done  (fill_done),
        .fill_line  (line_data),
        .rd_index   (rd_index),
        .rd_tag     (rd_tag),
        .rd_valid   (rd_valid),
        .rd_line    (rd_line),
        .miss_valid (miss_valid),
        .miss_tag   (miss_tag),
        .miss_index (miss_index),
        .miss_half  (miss_half)
    );

    icache_refill_buffer u_refill (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .start_half (start_half),
        .rvalid     (rvalid),
        .rlast      (rlast),
        .rdata_mem  (rdata_mem),
        .rready     (rready),
        .line_data  (line_data),
        .burst_done (burst_done)
    );

    icache_miss_ctrl u_miss_ctrl (
        .clk        (clk),
        .rst        (rst),
        .sweeping   (sweeping),
        .miss_valid (miss_valid),
        .miss_tag   (miss_tag),
        .miss_index (miss_index),
        .miss_half  (miss_half),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .start      (start),
        .start_half (start_half),
        .burst_done (burst_done),
        .fill_done  (fill_done),
        .way_we     (way_we),
        .wr_index   (wr_index),
        .wr_tag     (wr_tag),
        .wr_valid   (wr_valid)
    );

endmodule

// ==== source/icache_way_ram.sv ====
module icache_way_ram (
    input  logic                               clk,
    input  logic                               we,
    input  logic [icache_pkg::index_width-1:0] wr_index,
    input  logic [icache_pkg::tag_width-1:0]   wr_tag,
    input  logic                               wr_valid,
    input  logic [icache_pkg::line_width-1:0]  wr_line,
    input  logic [icache_pkg::index_width-1:0] rd_index,
    output logic [icache_pkg::tag_width-1:0]   rd_tag,
    output logic                               rd_valid,
    output logic [icache_pkg::line_width-1:0]  rd_line
);
    import icache_pkg::*;

    // per-set storage for this way
    logic [tag_width-1:0]  tag_mem  [num_sets];
    logic [line_width-1:0] line_mem [num_sets];
    logic [num_sets-1:0]   valid_mem;

    //////////////////////////////////////////////////
    // write port

    // sweep writes wr_valid low for every set
    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[wr_index]   <= wr_tag;
            valid_mem[wr_index] <= wr_valid;
            line_mem[wr_index]  <= wr_line;
        end
    end

    //////////////////////////////////////////////////
    // read port

    // registered read, same-set collision sees old contents
    always_ff @(posedge clk) begin
        rd_tag   <= tag_mem[rd_index];
        rd_valid <= valid_mem[rd_index];
        rd_line  <= line_mem[rd_index];
    end

endmodule

// ==== test/axi_mem_model.sv ====
module axi_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata_mem,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready
);
    timeunit 1ns;
    timeprecision 100ps;

    // each word holds its word address xor this key
    localparam logic [31:0] data_key = 32'h5a3c_96e1;

    integer      seed;
    logic        busy;
    logic [26:0] line_addr;
    logic [2:0]  start_word;
    int          beat_n;
    int          next_n;
    int          ar_wait;

    initial begin
        seed      = 32'hf8de;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rlast     = 1'b0;
        rdata_mem = '0;
    end

    always @(posedge clk) begin
        if (!rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            busy    <= 1'b0;
            beat_n  <= 0;
            ar_wait <= 0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                arready    <= 1'b0;
                busy       <= 1'b1;
                line_addr  <= araddr[31:5];
                start_word <= araddr[4:2];
                beat_n     <= 0;
            end else if (arvalid) begin
                // arready comes 0 to 3 cycles late
                if (ar_wait == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1;
                end
            end else begin
                ar_wait <= $random(seed) & 3;
            end
        end else begin
            next_n = beat_n + ((rvalid && rready) ? 1 : 0);
            if (rvalid && rready && rlast) begin
                busy   <= 1'b0;
                rvalid <= 1'b0;
                rlast  <= 1'b0;
            end else if (!rvalid || rready) begin
                // a gap roughly one beat in four
                if (($random(seed) & 3) == 0) begin
                    rvalid <= 1'b0;
                end else begin
                    rvalid    <= 1'b1;
                    rlast     <= (next_n == 7);
                    rdata_mem <= {2'b00, line_addr, start_word + 3'(next_n)} ^ data_key;
                end
            end
            beat_n <= next_n;
        end
    end

endmodule

// ==== test/tb_icache.sv ====
module tb_icache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          num_sets       = 128;
    localparam int          accept_timeout = 400;
    localparam int          done_timeout   = 400;
    localparam int          max_tests      = 32;
    localparam logic [31:0] data_key       = 32'h5a3c_96e1;

    typedef struct packed {
        logic [19:0] tag;
        logic [7:0]  index;
        logic        expect_hit;
        logic        chain;
    } entry_t;

    logic         clk;
    logic         rst;
    logic         req;
    logic [7:0]   index;
    logic [19:0]  tag;
    logic         index_ok;
    logic         data_ok;
    logic [127:0] rdata;
    logic [31:0]  araddr;
    logic         arvalid;
    logic         arready;
    logic [31:0]  rdata_mem;
    logic         rlast;
    logic         rvalid;
    logic         rready;

    entry_t       tbl [$];
    int           pending [$];
    int           cur_entry;
    int           cyc;
    int           popped;
    int           errors;
    int           checks;
    int           ar_total;
    bit           timed_out;
    int           acc_cycle [max_tests];
    int           resp_cycle [max_tests];
    int           ar_seen [max_tests];
    logic [31:0]  ar_addr [max_tests];
    logic [127:0] resp_data [max_tests];
    bit           done [max_tests];

    icache_top icache_top_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .index     (index),
        .tag       (tag),
        .index_ok  (index_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata_mem (rdata_mem),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    axi_mem_model axi_mem_model_i (
        .clk       (clk),
        .rst       (rst),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata_mem (rdata_mem),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers

    function automatic entry_t make_entry(logic [19:0] t, logic [7:0] ix, logic hit,
                                          logic chained);
        return '{tag: t, index: ix, expect_hit: hit, chain: chained};
    endfunction

    // word k of the half sits at bits k*32
    function automatic logic [127:0] expect_half(logic [19:0] t, logic [7:0] ix);
        logic [127:0] half;
        for (int k = 0; k < 4; k++) begin
            half[k*32 +: 32] = {2'b00, t, ix, 2'(k)} ^ data_key;
        end
        return half;
    endfunction

    task automatic flag_timeout(string why);
        $display("timeout: %s", why);
        timed_out = 1'b1;
    endtask

    task automatic check_data(string what, logic [127:0] got, logic [127:0] exp);
        checks = checks + 1;
        assert (got == exp)
            else begin
                $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
                errors = errors + 1;
            end
    endtask

    task automatic check_count(string what, int got, int exp);
        checks = checks + 1;
        assert (got == exp)
            else begin
                $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
                errors = errors + 1;
            end
    endtask

    // negedge samples, the memory side and data_ok stay quiet meanwhile
    task automatic wait_accept(output int waited);
        waited = 0;
        @(negedge clk);
        while (!index_ok && waited < accept_timeout) begin
            assert (!arvalid && !rready && !data_ok)
                else begin
                    $display("[ERROR] %0t: arvalid, rready or data_ok high while %s",
                             $time, "index_ok is low");
                    errors = errors + 1;
                end
            waited = waited + 1;
            @(negedge clk);
        end
        if (!index_ok) begin
            flag_timeout("index_ok never rose");
        end
    endtask

    task automatic wait_done(int j);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!done[j] && cycles < done_timeout) begin
            cycles = cycles + 1;
            @(posedge clk);
        end
        if (!done[j]) begin
            flag_timeout($sformatf("no data_ok for test %0d", j));
        end
    endtask

    task automatic check_entry(int j);
        int err_before;
        err_before = errors;
        check_data($sformatf("test %0d rdata", j), resp_data[j],
                   expect_half(tbl[j].tag, tbl[j].index));
        if (tbl[j].expect_hit) begin
            check_count($sformatf("test %0d ar handshakes", j), ar_seen[j], 0);
            check_count($sformatf("test %0d hit latency", j), resp_cycle[j] - acc_cycle[j], 1);
        end else begin
            check_count($sformatf("test %0d ar handshakes", j), ar_seen[j], 1);
            check_count($sformatf("test %0d araddr", j), ar_addr[j],
                        {tbl[j].tag, tbl[j].index, 4'h0});
        end
        // back-to-back requests go in and come out one per cycle
        if (j > 0 && tbl[j-1].chain) begin
            check_count($sformatf("test %0d accept gap", j), acc_cycle[j] - acc_cycle[j-1], 1);
            check_count($sformatf("test %0d data gap", j), resp_cycle[j] - resp_cycle[j-1], 1);
        end
        $display("test %0d tag %h index %h %s: %s", j, tbl[j].tag, tbl[j].index,
                 tbl[j].expect_hit ? "hit" : "miss", (errors == err_before) ? "ok" : "failed");
    endtask

    //////////////////////////////////////////////////
    // monitor

    always @(negedge clk) begin
        cyc = cyc + 1;
        if (rst) begin
            if (arvalid && arready) begin
                ar_total = ar_total + 1;
                assert (pending.size() != 0)
                    else begin
                        $display("ar handshake with no request outstanding at %0t", $time);
                        errors = errors + 1;
                    end
                if (pending.size() != 0) begin
                    ar_seen[pending[0]] = ar_seen[pending[0]] + 1;
                    ar_addr[pending[0]] = araddr;
                end
            end
            if (data_ok) begin
                assert (pending.size() != 0)
                    else begin
                        $display("data_ok with no request outstanding at %0t", $time);
                        errors = errors + 1;
                    end
                if (pending.size() != 0) begin
                    popped = pending.pop_front();
                    resp_cycle[popped] = cyc;
                    resp_data[popped]  = rdata;
                    done[popped]       = 1'b1;
                end
            end
            if (req && index_ok) begin
                acc_cycle[cur_entry] = cyc;
                pending.push_back(cur_entry);
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus table and loop

    task automatic load_table();
        // first miss, same half, other half
        tbl.push_back(make_entry(20'h12345, {7'd3, 1'b0}, 1'b0, 1'b0));
        tbl.push_back(make_entry(20'h12345, {7'd3, 1'b0}, 1'b1, 1'b0));
        tbl.push_back(make_entry(20'h12345, {7'd3, 1'b1}, 1'b1, 1'b0));
        // three hits held back to back
        tbl.push_back(make_entry(20'h12345, {7'd3, 1'b1}, 1'b1, 1'b1));
        tbl.push_back(make_entry(20'h12345, {7'd3, 1'b0}, 1'b1, 1'b1));
        tbl.push_back(make_entry(20'h12345, {7'd3, 1'b1}, 1'b1, 1'b0));
        // fill one set, E then evicts A
        tbl.push_back(make_entry(20'h0a0a0, {7'd9, 1'b0}, 1'b0, 1'b0));
        tbl.push_back(make_entry(20'h0b0b1, {7'd9, 1'b0}, 1'b0, 1'b0));
        tbl.push_back(make_entry(20'h0c0c2, {7'd9, 1'b0}, 1'b0, 1'b0));
        tbl.push_back(make_entry(20'h0d0d3, {7'd9, 1'b0}, 1'b0, 1'b0));
        tbl.push_back(make_entry(20'h0e0e4, {7'd9, 1'b0}, 1'b0, 1'b0));
        tbl.push_back(make_entry(20'h0b0b1, {7'd9, 1'b1}, 1'b1, 1'b0));
        tbl.push_back(make_entry(20'h0c0c2, {7'd9, 1'b0}, 1'b1, 1'b0));
        tbl.push_back(make_entry(20'h0d0d3, {7'd9, 1'b1}, 1'b1, 1'b0));
        tbl.push_back(make_entry(20'h0a0a0, {7'd9, 1'b0}, 1'b0, 1'b0));
        // last set, burst starting at word 4
        tbl.push_back(make_entry(20'hfffff, {7'd127, 1'b1}, 1'b0, 1'b0));
        tbl.push_back(make_entry(20'hfffff, {7'd127, 1'b0}, 1'b1, 1'b0));
    endtask

    initial begin
        int n_tests;
        int n_misses;
        int waited;
        int first;
        rst       = 1'b0;
        req       = 1'b0;
        index     = '0;
        tag       = '0;
        cur_entry = 0;
        cyc       = 0;
        errors    = 0;
        checks    = 0;
        ar_total  = 0;
        timed_out = 1'b0;
        first     = 0;
        n_misses  = 0;
        load_table();
        n_tests = tbl.size();
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            // first request goes out with the reset release
            if (i != 0) begin
                @(posedge clk);
            end
            req       <= 1'b1;
            tag       <= tbl[i].tag;
            index     <= tbl[i].index;
            cur_entry = i;
            if (!tbl[i].expect_hit) begin
                n_misses = n_misses + 1;
            end
            wait_accept(waited);
            if (timed_out) begin
                break;
            end
            if (i == 0) begin
                check_count("index_ok low cycles after reset", waited, num_sets);
                $display("test sweep: index_ok low for %0d cycles", waited);
            end
            if (!tbl[i].chain) begin
                @(posedge clk);
                req <= 1'b0;
                wait_done(i);
                if (timed_out) begin
                    break;
                end
                for (int j = first; j <= i; j++) begin
                    check_entry(j);
                end
                first = i + 1;
            end
        end
        check_count("total ar handshakes", ar_total, n_misses);
        $display("%0d tests, %0d checks, %0d errors, %0d ar bursts",
                 n_tests, checks, errors, ar_total);
        if (errors == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
